// File: tb/rv_exec_vectors.txt
# columns in hex: instr pc wb_en rd data next_pc illegal
# program order, later lines read registers written above
006281b3 00000100 1 03 00000000 00000104 0
ffb00093 00000104 1 01 fffffffb 00000108 0
00700113 00000108 1 02 00000007 0000010c 0
40110233 0000010c 1 04 0000000c 00000110 0
0020a2b3 00000110 1 05 00000001 00000114 0
0020b333 00000114 1 06 00000000 00000118 0
00311393 00000118 1 07 00000038 0000011c 0
4010d413 0000011c 1 08 fffffffd 00000120 0
01c0d493 00000120 1 09 0000000f 00000124 0
00724533 00000124 1 0a 00000034 00000128 0
007265b3 00000128 1 0b 0000003c 0000012c 0
0f00f613 0000012c 1 0c 000000f0 00000130 0
004116b3 00000130 1 0d 00007000 00000134 0
4020dab3 00000134 1 15 ffffffff 00000138 0
abcde737 00000138 1 0e abcde000 0000013c 0
00001797 0000013c 1 0f 0000113c 00000140 0
0100086f 00000140 1 10 00000144 00000150 0
003388e7 00000150 1 11 00000154 0000003a 0
00510013 00000154 1 00 0000000c 00000158 0
00206933 00000158 1 12 00000007 0000015c 0
00210463 00000160 0 00 00000000 00000168 0
00211463 00000168 0 00 00000000 0000016c 0
fe20c8e3 00000170 0 00 00000000 00000160 0
0020d663 00000174 0 00 00000000 00000178 0
0020e663 00000178 0 00 00000000 0000017c 0
fe20f0e3 00000180 0 00 00000000 00000160 0
0020a223 00000184 0 00 00000000 00000188 0
00012983 00000188 0 00 00000000 0000018c 0
0000007f 0000018c 0 00 00000000 00000190 1
0009ea33 00000190 1 14 00000000 00000194 0

// File: sources.f
+incdir+rtl
rtl/rv_exec_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/exec_sequencer.sv
rtl/rv_exec_top.sv
tb/clk_gen.sv
tb/rv_exec_tb.sv

// File: tb/rv_exec_tb.sv
`default_nettype none

module rv_exec_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // one line of the vector file
    typedef struct packed {
        logic [31:0]      instr;
        logic [31:0]      pc;
        rv_exec_pkg::wb_t exp;
    } vector_t;

    logic                   clk;
    logic                   rst_n;
    logic                   req;
    rv_exec_pkg::exec_req_t request;
    logic                   ack;
    rv_exec_pkg::wb_t       result;

    vector_t vectors[$];
    int      checks_failed;

    clk_gen clk_gen_inst (
        .clk (clk)
    );

    rv_exec_top rv_exec_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .request (request),
        .ack     (ack),
        .result  (result)
    );

    task automatic stop_on_mismatch(input string what, input logic [31:0] got,
                                    input logic [31:0] exp);
        checks_failed++;
        $display("Error: time %0t: %s got %h expected %h", $time, what, got, exp);
        $display("Result: FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_mismatch(what, got, exp);
        end
    endtask

    // all fields of the write-back record against the vector
    task automatic check_record(input string when, input int idx,
                                input rv_exec_pkg::wb_t exp);
        check_value($sformatf("vector %0d wb_en %s", idx, when), result.wb_en, exp.wb_en);
        check_value($sformatf("vector %0d rd %s", idx, when), result.rd, exp.rd);
        check_value($sformatf("vector %0d data %s", idx, when), result.data, exp.data);
        check_value($sformatf("vector %0d next_pc %s", idx, when),
                    result.next_pc, exp.next_pc);
        check_value($sformatf("vector %0d illegal %s", idx, when),
                    result.illegal, exp.illegal);
    endtask

    // comment and blank lines yield no fields and are skipped
    task automatic load_vectors();
        int             fd;
        int             n;
        reg [8*128-1:0] line;
        logic [31:0]    f_instr;
        logic [31:0]    f_pc;
        logic [31:0]    f_wb;
        logic [31:0]    f_rd;
        logic [31:0]    f_data;
        logic [31:0]    f_next;
        logic [31:0]    f_ill;
        vector_t        v;
        fd = $fopen("tb/rv_exec_vectors.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the vector file tb/rv_exec_vectors.txt");
            $display("Result: FAILED");
            $fatal(1, "missing vector file");
        end
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_instr, f_pc, f_wb, f_rd, f_data, f_next, f_ill);
            if (n == 7) begin
                v.instr       = f_instr;
                v.pc          = f_pc;
                v.exp.wb_en   = f_wb[0];
                v.exp.rd      = f_rd[4:0];
                v.exp.data    = f_data;
                v.exp.next_pc = f_next;
                v.exp.illegal = f_ill[0];
                vectors.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // budget per handshake covers gaps, latency and long holds
    task automatic watch_for_hang(input int limit);
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, a handshake hung", limit);
        $display("Result: FAILED");
        $fatal(1, "watchdog timeout");
    endtask

    task automatic run_handshake(input vector_t v, input int idx);
        int gap;
        int hold;
        gap  = $urandom % 4;
        // every eighth request keeps req up well past ack
        hold = (idx % 8 == 7) ? 10 : $urandom % 4;
        repeat (gap) @(negedge clk);
        // phase 0, unit must be idle
        check_value($sformatf("vector %0d ack before req", idx), ack, 1'b0);
        request.instr = v.instr;
        request.pc    = v.pc;
        req           = 1'b1;
        // phase 2, wait for ack
        do begin
            @(negedge clk);
        end while (!ack);
        check_record("at ack", idx, v.exp);
        // back-pressure, ack and record stay put
        repeat (hold) begin
            @(negedge clk);
            check_value($sformatf("vector %0d ack while req held", idx), ack, 1'b1);
            check_record("while req held", idx, v.exp);
        end
        // phase 3, drop req and scramble the bundle
        req     = 1'b0;
        request = {$urandom, $urandom};
        do begin
            @(negedge clk);
        end while (ack);
        // record held after ack falls
        check_record("after ack", idx, v.exp);
    endtask

    initial begin
        int limit;
        rst_n         = 1'b0;
        req           = 1'b0;
        request       = '0;
        checks_failed = 0;
        void'($urandom(32'h54f08018));
        load_vectors();
        assert (vectors.size() > 0) else begin
            $display("the vector file holds no vectors");
            $display("Result: FAILED");
            $fatal(1, "empty vector file");
        end
        limit = vectors.size() * 20 + 8;
        fork
            watch_for_hang(limit);
        join_none
        // reset for 8 edges, released on a falling edge
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("ack after reset", ack, 1'b0);
        check_value("wb_en after reset", result.wb_en, 1'b0);
        foreach (vectors[i]) begin
            run_handshake(vectors[i], i);
        end
        if (checks_failed == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // free running, 10 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_exec_top.sv
`default_nettype none

`include "rv_exec_macros.svh"

module rv_exec_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  rv_exec_pkg::exec_req_t request,
    output logic                   ack,
    output rv_exec_pkg::wb_t       result
);

    rv_exec_pkg::exec_req_t held;
    rv_exec_pkg::decoded_t  dec;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;
    logic [`RV_XLEN-1:0]    alu_result;
    logic [`RV_XLEN-1:0]    next_pc;
    logic                   we;
    logic [`RV_REG_AW-1:0]  waddr;
    logic [`RV_XLEN-1:0]    wdata;

    // handshake, capture and write-back
    exec_sequencer exec_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .request    (request),
        .ack        (ack),
        .held       (held),
        .dec        (dec),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .result     (result)
    );

    instr_decoder instr_decoder_inst (
        .instr (held.instr),
        .dec   (dec)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    alu alu_inst (
        .dec      (dec),
        .pc       (held.pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    // next pc from the same operands
    branch_unit branch_unit_inst (
        .dec      (dec),
        .pc       (held.pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc)
    );

endmodule

`default_nettype wire

// File: rtl/exec_sequencer.sv
`default_nettype none

`include "rv_exec_macros.svh"

module exec_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  rv_exec_pkg::exec_req_t request,
    output logic                   ack,
    output rv_exec_pkg::exec_req_t held,
    input  rv_exec_pkg::decoded_t  dec,
    input  logic [`RV_XLEN-1:0]    alu_result,
    input  logic [`RV_XLEN-1:0]    next_pc,
    output logic                   we,
    output logic [`RV_REG_AW-1:0]  waddr,
    output logic [`RV_XLEN-1:0]    wdata,
    output rv_exec_pkg::wb_t       result
);

    rv_exec_pkg::seq_state_t state;
    logic                    wb_en;

    // write condition shared by port and record
    assign wb_en = dec.writes_rd && !dec.illegal;

    // single write pulse in exec
    assign we    = (state == rv_exec_pkg::EXEC) && wb_en;
    assign waddr = dec.rd;
    assign wdata = alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= rv_exec_pkg::IDLE;
            ack    <= 1'b0;
            result <= '0;
        end else begin
            case (state)
                rv_exec_pkg::IDLE: begin
                    // new work only accepted here
                    if (req) begin
                        state <= rv_exec_pkg::EXEC;
                    end
                end
                rv_exec_pkg::EXEC: begin
                    result.wb_en   <= wb_en;
                    // rd and data zeroed when nothing is written
                    result.rd      <= wb_en ? dec.rd : '0;
                    result.data    <= wb_en ? alu_result : '0;
                    result.next_pc <= next_pc;
                    result.illegal <= dec.illegal;
                    ack            <= 1'b1;
                    state          <= rv_exec_pkg::RESP;
                end
                rv_exec_pkg::RESP: begin
                    // hold until requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= rv_exec_pkg::IDLE;
                    end
                end
                default: begin
                    ack   <= 1'b0;
                    state <= rv_exec_pkg::IDLE;
                end
            endcase
        end
    end

    // capture instr and pc on acceptance
    always_ff @(posedge clk) begin
        if (state == rv_exec_pkg::IDLE && req) begin
            held <= request;
        end
    end

    // req was up on the edge that raised ack
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    // write only in the cycle right before ack rises, once per handshake
    a_we_exec_only: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> !ack ##1 (!we && ack));

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`default_nettype none

`include "rv_exec_macros.svh"

module branch_unit (
    input  rv_exec_pkg::decoded_t dec,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output logic [`RV_XLEN-1:0]   next_pc
);

    logic                taken;
    logic [`RV_XLEN-1:0] jalr_sum;

    // branch condition by funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            // 010 and 011 are not branches
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_data + dec.imm;

    always_comb begin
        if ((dec.is_branch && taken) || dec.is_jal) begin
            next_pc = pc + dec.imm;
        end else if (dec.is_jalr) begin
            // target lsb forced to zero
            next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
        end else begin
            next_pc = pc + `RV_PC_STEP;
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

`include "rv_exec_macros.svh"

module alu (
    input  rv_exec_pkg::decoded_t dec,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output logic [`RV_XLEN-1:0]   result
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_out;

    // operand muxes
    assign op_a  = dec.use_pc ? pc : rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    // only low 5 bits shift
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_exec_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_exec_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_exec_pkg::ALU_SLL:    alu_out = op_a << shamt;
            rv_exec_pkg::ALU_SLT: begin
                alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_exec_pkg::ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            rv_exec_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_exec_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            rv_exec_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            rv_exec_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_exec_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_exec_pkg::ALU_PASS_B: alu_out = op_b;
            default:                 alu_out = '0;
        endcase
    end

    // jumps write the link address instead
    always_comb begin
        if (dec.is_jal || dec.is_jalr) begin
            result = pc + `RV_PC_STEP;
        end else begin
            result = alu_out;
        end
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

`include "rv_exec_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    // all registers read zero after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 hardwired to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // written value visible on the following cycle
    a_write_lands: assert property (@(posedge clk) disable iff (!rst_n)
        (we && waddr != '0) |=> regs[$past(waddr)] == $past(wdata));

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
`default_nettype none

`include "rv_exec_macros.svh"

module instr_decoder (
    input  logic [`RV_XLEN-1:0] instr,
    output rv_exec_pkg::decoded_t dec
);

    always_comb begin
        // unused fields stay zero
        dec = '0;
        dec.opcode = rv_exec_pkg::opcode_t'(instr[6:0]);

        case (dec.opcode)
            rv_exec_pkg::OP_R_TYPE: begin
                dec.rd        = instr[11:7];
                dec.funct3    = instr[14:12];
                dec.rs1       = instr[19:15];
                dec.rs2       = instr[24:20];
                dec.funct7    = instr[31:25];
                dec.writes_rd = 1'b1;
            end

            // i-format, also jalr and load
            rv_exec_pkg::OP_I_TYPE, rv_exec_pkg::OP_LOAD, rv_exec_pkg::OP_JALR: begin
                dec.rd        = instr[11:7];
                dec.funct3    = instr[14:12];
                dec.rs1       = instr[19:15];
                dec.funct7    = instr[31:25];
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.use_imm   = 1'b1;
                // load has no data memory, so no write
                dec.writes_rd = (dec.opcode != rv_exec_pkg::OP_LOAD);
                dec.is_jalr   = (dec.opcode == rv_exec_pkg::OP_JALR);
            end

            rv_exec_pkg::OP_STORE: begin
                dec.funct3  = instr[14:12];
                dec.rs1     = instr[19:15];
                dec.rs2     = instr[24:20];
                dec.imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec.use_imm = 1'b1;
            end

            // b-format, imm bit 0 implied zero
            rv_exec_pkg::OP_BRANCH: begin
                dec.funct3    = instr[14:12];
                dec.rs1       = instr[19:15];
                dec.rs2       = instr[24:20];
                dec.imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                dec.alu_op    = rv_exec_pkg::ALU_SUB;
                dec.is_branch = 1'b1;
            end

            // j-format: imm[20|10:1|11|19:12]
            rv_exec_pkg::OP_JAL: begin
                dec.rd        = instr[11:7];
                dec.imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.writes_rd = 1'b1;
                dec.is_jal    = 1'b1;
            end

            // u-format
            rv_exec_pkg::OP_LUI, rv_exec_pkg::OP_AUIPC: begin
                dec.rd        = instr[11:7];
                dec.imm       = {instr[31:12], 12'b0};
                dec.use_imm   = 1'b1;
                dec.use_pc    = (dec.opcode == rv_exec_pkg::OP_AUIPC);
                dec.writes_rd = 1'b1;
                if (dec.opcode == rv_exec_pkg::OP_LUI) begin
                    dec.alu_op = rv_exec_pkg::ALU_PASS_B;
                end
            end

            default: begin
                dec.illegal = 1'b1;
            end
        endcase

        // alu op for register and immediate arithmetic
        if (dec.opcode == rv_exec_pkg::OP_R_TYPE || dec.opcode == rv_exec_pkg::OP_I_TYPE) begin
            case (dec.funct3)
                3'b000: begin
                    // sub only exists in r-type
                    if (dec.opcode == rv_exec_pkg::OP_R_TYPE && dec.funct7[5]) begin
                        dec.alu_op = rv_exec_pkg::ALU_SUB;
                    end else begin
                        dec.alu_op = rv_exec_pkg::ALU_ADD;
                    end
                end
                3'b001: dec.alu_op = rv_exec_pkg::ALU_SLL;
                3'b010: dec.alu_op = rv_exec_pkg::ALU_SLT;
                3'b011: dec.alu_op = rv_exec_pkg::ALU_SLTU;
                3'b100: dec.alu_op = rv_exec_pkg::ALU_XOR;
                3'b101: dec.alu_op = dec.funct7[5] ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                3'b110: dec.alu_op = rv_exec_pkg::ALU_OR;
                default: dec.alu_op = rv_exec_pkg::ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_macros.svh"

package rv_exec_pkg;

    // rv32i major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_R_TYPE = 7'b0110011,
        OP_I_TYPE = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // handshake sequencer states
    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        RESP
    } seq_state_t;

    // request bundle from the requester
    typedef struct packed {
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] pc;
    } exec_req_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [`RV_XLEN-1:0]   imm;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  use_pc;
        logic                  writes_rd;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  illegal;
    } decoded_t;

    // write-back record returned with ack
    typedef struct packed {
        logic                  wb_en;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
        logic [`RV_XLEN-1:0]   next_pc;
        logic                  illegal;
    } wb_t;

endpackage

`default_nettype wire

// File: rtl/rv_exec_macros.svh
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// data path and pc width
`define RV_XLEN 32

// register index width
`define RV_REG_AW 5

// architectural register count
`define RV_NUM_REGS 32

// sequential pc increment
`define RV_PC_STEP 32'd4

`endif
